//--- run.sh
#!/bin/sh
# compile the spi slave testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module spi_ram_btn_tb -f vlog.f -o spi_ram_btn_sim

# a failed assertion stops the simulation, the output still decides
out=$(./obj_dir/spi_ram_btn_sim || true)
echo "$out"

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

//--- src/btn_irq_ctrl.sv
// button debouncer with change interrupt and latched button value
`timescale 1ns/1ns
`default_nettype none

`include "spi_btn_defines.svh"

module btn_irq_ctrl #(
  // width of the debounce counter, the top bit marks the hold time as over
  parameter int debounce_bits = 20
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`BTN_COUNT-1:0] btn,
  input  logic                  irq_clear,
  output logic                  irq,
  output logic [`BTN_COUNT-1:0] btn_value
);

  // raw buttons are asynchronous, two stages before use
  logic [`BTN_COUNT-1:0] btn_meta;
  logic [`BTN_COUNT-1:0] btn_samp;

  logic [debounce_bits-1:0] cnt;
  logic                     settled;

  always_ff @(posedge clk)
  begin
    btn_meta <= btn;
    btn_samp <= btn_meta;
  end

  assign settled = cnt[debounce_bits-1];

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      irq       <= 1'b0;
      btn_value <= '0;
      // start saturated so the first change is taken at once
      cnt       <= {1'b1, {(debounce_bits-1){1'b0}}};
    end
    else if (irq_clear)
    begin
      // host read of the status register
      irq <= 1'b0;
    end
    else
    begin
      // accept a change only after the hold time and with no interrupt pending
      if (btn_samp != btn_value && settled && !irq)
      begin
        btn_value <= btn_samp;
        irq       <= 1'b1;
        cnt       <= '0;
      end
      else if (!settled)
        cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/spi_btn_defines.svh
// spi ram/button slave constants: command codes, region bytes and sizes

`ifndef SPI_BTN_DEFINES_SVH
`define SPI_BTN_DEFINES_SVH

// host side bus address width, sent as four bytes msb first
`define SPI_ADDR_BITS 32

// first byte of every frame
`define SPI_CMD_WRITE 8'h00
`define SPI_CMD_READ 8'h01

// top address byte selects a register region
// interrupt status, irq flag in bit 7
`define SPI_REGION_IRQ 8'hF1
// debounced buttons, zero above the button bits
`define SPI_REGION_BTN 8'hFB

// ram index width, 1024 bytes
// upper address bits alias onto the same bytes
`define RAM_ADDR_BITS 10

// number of button inputs
`define BTN_COUNT 7

`endif

//--- src/spi_btn_pkg.sv
// shared types for the spi slave: wishbone request/response and decoder states

`default_nettype none

`include "spi_btn_defines.svh"

package spi_btn_pkg;

  // wishbone classic master side, stb and we are qualified by cyc
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [`SPI_ADDR_BITS-1:0] adr;
    // write data, one byte per access
    logic [7:0]                dat;
  } wb_req_t;

  // slave side, ack lasts exactly one clk
  typedef struct packed {
    logic       ack;
    // read data, valid with ack
    logic [7:0] dat;
  } wb_rsp_t;

  // frame decoder states
  // IDLE waits for a csn falling edge, or for csn to rise after a bad command
  // CMD takes the first byte
  // ADDR takes four address bytes
  // DUMMY is the read turnaround byte, its mosi content is dropped
  // DATA carries payload bytes until csn rises
  typedef enum logic [2:0] {
    IDLE,
    CMD,
    ADDR,
    DUMMY,
    DATA
  } frame_state_e;

endpackage

`default_nettype wire

//--- src/spi_bus_responder.sv
// wishbone slave serving the on-chip ram, the interrupt status and the button register
`timescale 1ns/1ns
`default_nettype none

`include "spi_btn_defines.svh"

module spi_bus_responder (
  input  logic                    clk,
  input  logic                    arst_n,
  input  spi_btn_pkg::wb_req_t     wb_req,
  output spi_btn_pkg::wb_rsp_t     wb_rsp,
  input  logic                    irq_flag,
  input  logic [`BTN_COUNT-1:0]   btn_value,
  output logic                    irq_clear
);

  logic [7:0] ram [0:(1 << `RAM_ADDR_BITS)-1];

  logic [7:0]               region;
  logic [`RAM_ADDR_BITS-1:0] ram_idx;
  logic                     access;
  logic                     is_ram;

  logic       ack_q;
  logic [7:0] rdat_q;

  // top address byte picks the region
  assign region  = wb_req.adr[`SPI_ADDR_BITS-1 -: 8];
  // ram ignores address bits above its index, so those alias
  assign ram_idx = wb_req.adr[`RAM_ADDR_BITS-1:0];
  assign is_ram  = (region != `SPI_REGION_IRQ) && (region != `SPI_REGION_BTN);

  // first clk of stb only, blocked while ack is out
  assign access = wb_req.cyc && wb_req.stb && !ack_q;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ack_q     <= 1'b0;
      irq_clear <= 1'b0;
    end
    else
    begin
      // registered ack, one clk after stb
      ack_q     <= access;
      // reading status clears the flag, pulse lines up with ack
      irq_clear <= access && !wb_req.we && (region == `SPI_REGION_IRQ);
    end
  end

  // register regions take writes without effect
  always_ff @(posedge clk)
  begin
    if (access && wb_req.we && is_ram)
      ram[ram_idx] <= wb_req.dat;
  end

  // read mux, captured once per access
  always_ff @(posedge clk)
  begin
    if (access)
    begin
      case (region)
        `SPI_REGION_IRQ: rdat_q <= {irq_flag, 7'd0};
        `SPI_REGION_BTN: rdat_q <= {{(8-`BTN_COUNT){1'b0}}, btn_value};
        default:         rdat_q <= ram[ram_idx];
      endcase
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rdat_q;

endmodule

`default_nettype wire

//--- src/spi_frame_decode.sv
// spi frame decoder: oversamples the spi lines, decodes command and address, issues bus cycles
`timescale 1ns/1ns
`default_nettype none

`include "spi_btn_defines.svh"

module spi_frame_decode (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                csn,
  input  logic                sclk,
  input  logic                mosi,
  output spi_btn_pkg::wb_req_t wb_req,
  input  spi_btn_pkg::wb_rsp_t wb_rsp,
  output logic                sclk_fall,
  output logic                load,
  output logic [7:0]          load_data
);

  // two flop synchronizers, [1] is the usable copy
  logic [1:0] csn_sync;
  logic [1:0] sclk_sync;
  logic [1:0] mosi_sync;
  // previous synchronized values for edge detection
  logic       csn_d;
  logic       sclk_d;

  logic       sclk_rise;
  logic       byte_end;
  logic [7:0] rx_byte;

  // control state
  spi_btn_pkg::frame_state_e state;
  logic [2:0] bit_cnt;
  logic [1:0] addr_cnt;
  logic       is_write;
  logic       cyc;
  logic       first_load;

  // payload
  logic [6:0]                shreg;
  logic [`SPI_ADDR_BITS-1:0] addr;
  logic [7:0]                wdat;
  logic [7:0]                first_byte;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // csn idles high, so the frame does not start out of reset
      csn_sync  <= 2'b11;
      sclk_sync <= 2'b00;
      mosi_sync <= 2'b00;
      csn_d     <= 1'b1;
      sclk_d    <= 1'b0;
    end
    else
    begin
      csn_sync  <= {csn_sync[0], csn};
      sclk_sync <= {sclk_sync[0], sclk};
      mosi_sync <= {mosi_sync[0], mosi};
      csn_d     <= csn_sync[1];
      sclk_d    <= sclk_sync[1];
    end
  end

  // mode 0: mosi sampled on rising sclk, miso changes on falling sclk
  assign sclk_rise = sclk_sync[1] & ~sclk_d & ~csn_sync[1];
  assign sclk_fall = ~sclk_sync[1] & sclk_d;

  // eighth rising edge closes a byte, the last bit comes straight from the synchronizer
  assign byte_end = sclk_rise && (bit_cnt == 3'd7);
  assign rx_byte  = {shreg, mosi_sync[1]};

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state      <= spi_btn_pkg::IDLE;
      bit_cnt    <= 3'd0;
      addr_cnt   <= 2'd0;
      is_write   <= 1'b0;
      cyc        <= 1'b0;
      first_load <= 1'b0;
    end
    else
    begin
      first_load <= 1'b0;
      // master drops the cycle in the clk after ack
      if (wb_rsp.ack)
        cyc <= 1'b0;
      if (csn_sync[1])
      begin
        // frame over, an outstanding cycle still completes
        bit_cnt <= 3'd0;
        state   <= spi_btn_pkg::IDLE;
      end
      else
      begin
        if (sclk_rise)
          bit_cnt <= bit_cnt + 3'd1;
        case (state)
          spi_btn_pkg::IDLE:
            // only a fresh csn falling edge opens a frame
            if (csn_d)
              state <= spi_btn_pkg::CMD;
          spi_btn_pkg::CMD:
            if (byte_end)
            begin
              is_write <= (rx_byte == `SPI_CMD_WRITE);
              addr_cnt <= 2'd0;
              if (rx_byte == `SPI_CMD_WRITE || rx_byte == `SPI_CMD_READ)
                state <= spi_btn_pkg::ADDR;
              else
                state <= spi_btn_pkg::IDLE;
            end
          spi_btn_pkg::ADDR:
            if (byte_end)
            begin
              addr_cnt <= addr_cnt + 2'd1;
              if (addr_cnt == 2'd3)
              begin
                if (is_write)
                  state <= spi_btn_pkg::DATA;
                else
                begin
                  // prefetch the first read byte during the dummy byte
                  state <= spi_btn_pkg::DUMMY;
                  cyc   <= 1'b1;
                end
              end
            end
          spi_btn_pkg::DUMMY:
            if (byte_end)
            begin
              // hand the prefetched byte over for the first data byte
              state      <= spi_btn_pkg::DATA;
              first_load <= 1'b1;
            end
          spi_btn_pkg::DATA:
            // write the received byte, or prefetch the next read byte
            if (byte_end)
              cyc <= 1'b1;
          default:
            state <= spi_btn_pkg::IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sclk_rise)
      shreg <= rx_byte[6:0];
    // address bytes arrive msb first
    if (byte_end && state == spi_btn_pkg::ADDR)
      addr <= {addr[`SPI_ADDR_BITS-9:0], rx_byte};
    // auto increment after every access
    if (wb_rsp.ack)
      addr <= addr + 1'b1;
    if (byte_end)
      wdat <= rx_byte;
    if (wb_rsp.ack && state == spi_btn_pkg::DUMMY)
      first_byte <= wb_rsp.dat;
  end

  // stb follows cyc, one access at a time
  assign wb_req.cyc = cyc;
  assign wb_req.stb = cyc;
  assign wb_req.we  = is_write;
  assign wb_req.adr = addr;
  assign wb_req.dat = wdat;

  // data byte reads go to the shifter on their ack, the first one waits for the dummy end
  assign load      = (wb_rsp.ack && !is_write && state == spi_btn_pkg::DATA) || first_load;
  assign load_data = first_load ? first_byte : wb_rsp.dat;

endmodule

`default_nettype wire

//--- src/spi_miso_shift.sv
// miso shifter: takes read bytes and shifts them out msb first on falling sclk
`timescale 1ns/1ns
`default_nettype none

module spi_miso_shift (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       csn,
  input  logic       sclk_fall,
  input  logic       load,
  input  logic [7:0] load_data,
  output logic       miso,
  output logic       miso_oe
);

  logic [1:0] csn_sync;
  logic [7:0] shreg;
  // a loaded byte waits here for the falling edge that ends the current byte
  logic       pend;
  logic [7:0] pend_data;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      csn_sync <= 2'b11;
      shreg    <= 8'd0;
      pend     <= 1'b0;
    end
    else
    begin
      csn_sync <= {csn_sync[0], csn};
      if (csn_sync[1])
      begin
        // deselected, drop anything queued
        shreg <= 8'd0;
        pend  <= 1'b0;
      end
      else
      begin
        if (load)
          pend <= 1'b1;
        else if (sclk_fall)
          pend <= 1'b0;
        if (sclk_fall)
        begin
          if (pend)
            shreg <= pend_data;
          else
            shreg <= {shreg[6:0], 1'b0};
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
      pend_data <= load_data;
  end

  // zeros shift in, so miso is 0 once a byte is used up
  assign miso    = shreg[7];
  assign miso_oe = ~csn_sync[1];

endmodule

`default_nettype wire

//--- src/spi_ram_btn_top.sv
// spi slave with ram and button interrupt: decode, bus responder and miso shifter
`timescale 1ns/1ns
`default_nettype none

`include "spi_btn_defines.svh"

module spi_ram_btn_top #(
  // debounce counter width, larger is slower
  parameter int debounce_bits = 20
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  csn,
  input  logic                  sclk,
  input  logic                  mosi,
  input  logic [`BTN_COUNT-1:0] btn,
  output logic                  miso,
  output logic                  miso_oe,
  output logic                  irq
);

  spi_btn_pkg::wb_req_t wb_req;
  spi_btn_pkg::wb_rsp_t wb_rsp;

  logic                  sclk_fall;
  logic                  load;
  logic [7:0]            load_data;
  logic                  irq_clear;
  logic [`BTN_COUNT-1:0] btn_value;

  // decode stage
  spi_frame_decode u_decode (
    .clk       (clk),
    .arst_n    (arst_n),
    .csn       (csn),
    .sclk      (sclk),
    .mosi      (mosi),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .sclk_fall (sclk_fall),
    .load      (load),
    .load_data (load_data)
  );

  // execute stage
  spi_bus_responder u_responder (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .irq_flag  (irq),
    .btn_value (btn_value),
    .irq_clear (irq_clear)
  );

  btn_irq_ctrl #(
    .debounce_bits (debounce_bits)
  ) u_btn (
    .clk       (clk),
    .arst_n    (arst_n),
    .btn       (btn),
    .irq_clear (irq_clear),
    .irq       (irq),
    .btn_value (btn_value)
  );

  // result stage
  spi_miso_shift u_miso (
    .clk       (clk),
    .arst_n    (arst_n),
    .csn       (csn),
    .sclk_fall (sclk_fall),
    .load      (load),
    .load_data (load_data),
    .miso      (miso),
    .miso_oe   (miso_oe)
  );

endmodule

`default_nettype wire

//--- tb/spi_ram_btn_props.sv
// bound checks on the wishbone link, the interrupt line and the miso enable
`timescale 1ns/1ns
`default_nettype none

module spi_ram_btn_props (
  input logic                 clk,
  input logic                 arst_n,
  input spi_btn_pkg::wb_req_t wb_req,
  input spi_btn_pkg::wb_rsp_t wb_rsp,
  input logic                 irq,
  input logic                 miso_oe
);

  // number of failed assertions
  int unsigned fail_count = 0;

  // slave may only ack a live strobe
  ack_in_stb: assert property (@(posedge clk) disable iff (!arst_n)
    wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
  else
  begin
    $error("ack seen without cyc and stb");
    fail_count = fail_count + 1;
  end

  // registered ack is a single clk pulse, and the master lets go of stb right after it
  ack_single: assert property (@(posedge clk) disable iff (!arst_n)
    wb_rsp.ack |=> (!wb_rsp.ack && !wb_req.stb))
  else
  begin
    $error("ack held for two cycles or stb kept after ack");
    fail_count = fail_count + 1;
  end

  // quiet outputs on reset release
  reset_quiet: assert property (@(posedge clk)
    $rose(arst_n) |-> (!irq && !miso_oe))
  else
  begin
    $error("irq or miso_oe high after reset");
    fail_count = fail_count + 1;
  end

endmodule

bind spi_ram_btn_top spi_ram_btn_props u_props (
  .clk     (clk),
  .arst_n  (arst_n),
  .wb_req  (wb_req),
  .wb_rsp  (wb_rsp),
  .irq     (irq),
  .miso_oe (miso_oe)
);

`default_nettype wire

//--- tb/spi_ram_btn_tb.sv
// testbench for the spi ram/button slave: spi host, reference model, checks and watchdog
`timescale 1ns/1ns
`default_nettype none

`include "spi_btn_defines.svh"

module spi_ram_btn_tb;

  localparam int CLK_NS = 20;
  // sclk half period in clk cycles
  localparam int HALF = 10;
  localparam int DEB_BITS = 6;
  // debounce hold, button synchronizer and some margin
  localparam int IRQ_WAIT = (1 << (DEB_BITS - 1)) + 8;
  // spi bytes and frames over all tests
  localparam int SPI_BYTES = 152;
  localparam int SPI_FRAMES = 14;
  localparam int DEB_WAITS = 4;
  // each frame adds two sclk periods of select setup, hold and gap
  localparam int FRAME_CLKS = 2 * HALF * (8 * SPI_BYTES + 2 * SPI_FRAMES);
  localparam int WATCHDOG_NS = 2 * (FRAME_CLKS + DEB_WAITS * IRQ_WAIT + 8) * CLK_NS;

  logic clk;
  logic arst_n;
  logic csn;
  logic sclk;
  logic mosi;
  logic [`BTN_COUNT-1:0] btn;
  logic miso;
  logic miso_oe;
  logic irq;

  // reference model
  logic [7:0] ref_ram [0:(1 << `RAM_ADDR_BITS)-1];
  logic [`BTN_COUNT-1:0] ref_btn;
  logic ref_irq;

  logic [31:0] rand_state = 32'd24;
  int checks = 0;
  int errors = 0;
  int test_no = 0;
  int test_err_base = 0;
  int csn_high = 0;

  // received bytes waiting for the compare process
  logic [7:0] got_q[$];
  logic [7:0] exp_q[$];
  logic [31:0] adr_q[$];
  logic [7:0] cmp_got;
  logic [7:0] cmp_exp;
  logic [31:0] cmp_adr;

  logic [31:0] seed_word;
  logic [31:0] base_adr;
  logic [31:0] alias_adr;

  spi_ram_btn_top #(
    .debounce_bits (DEB_BITS)
  ) UUT (
    .clk     (clk),
    .arst_n  (arst_n),
    .csn     (csn),
    .sclk    (sclk),
    .mosi    (mosi),
    .btn     (btn),
    .miso    (miso),
    .miso_oe (miso_oe),
    .irq     (irq)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // a random button value that differs from prev
  function automatic logic [`BTN_COUNT-1:0] new_btn(input logic [`BTN_COUNT-1:0] prev);
    logic [31:0] r;
    logic [`BTN_COUNT-1:0] b;
    b = prev;
    while (b == prev)
    begin
      r = next_rand();
      b = r[16 +: `BTN_COUNT];
    end
    return b;
  endfunction

  // what a read of adr must return, by region
  function automatic logic [7:0] expected_byte(input logic [31:0] adr);
    if (adr[31:24] == `SPI_REGION_IRQ)
      return {ref_irq, 7'd0};
    else if (adr[31:24] == `SPI_REGION_BTN)
      return {{(8-`BTN_COUNT){1'b0}}, ref_btn};
    else
      return ref_ram[adr[`RAM_ADDR_BITS-1:0]];
  endfunction

  // register regions ignore writes
  task automatic model_write(input logic [31:0] adr, input logic [7:0] d);
    if (adr[31:24] != `SPI_REGION_IRQ && adr[31:24] != `SPI_REGION_BTN)
      ref_ram[adr[`RAM_ADDR_BITS-1:0]] = d;
  endtask

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // mode 0 byte, mosi set while sclk low, miso taken at the rising edge
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--)
    begin
      mosi = tx[i];
      wait_clks(HALF);
      rx[i] = miso;
      sclk = 1'b1;
      wait_clks(HALF);
      sclk = 1'b0;
    end
  endtask

  task automatic frame_start(input logic [7:0] cmd, input logic [31:0] adr);
    logic [7:0] rx;
    csn = 1'b0;
    wait_clks(HALF);
    spi_byte(cmd, rx);
    // address msb first
    for (int i = 3; i >= 0; i--)
      spi_byte(adr[8*i +: 8], rx);
  endtask

  task automatic frame_end();
    wait_clks(HALF);
    csn = 1'b1;
    mosi = 1'b0;
    wait_clks(2 * HALF);
  endtask

  task automatic spi_write(input logic [31:0] adr, input int n);
    logic [31:0] r;
    logic [7:0] d;
    logic [7:0] rx;
    frame_start(`SPI_CMD_WRITE, adr);
    for (int i = 0; i < n; i++)
    begin
      r = next_rand();
      d = r[23:16];
      spi_byte(d, rx);
      model_write(adr + i, d);
    end
    frame_end();
  endtask

  task automatic spi_read(input logic [31:0] adr, input int n);
    logic [7:0] rx;
    frame_start(`SPI_CMD_READ, adr);
    // turnaround byte, the first data byte is fetched meanwhile
    spi_byte(8'h00, rx);
    for (int i = 0; i < n; i++)
    begin
      spi_byte(8'h00, rx);
      got_q.push_back(rx);
      exp_q.push_back(expected_byte(adr + i));
      adr_q.push_back(adr + i);
    end
    frame_end();
  endtask

  task automatic check_irq(input logic exp);
    checks++;
    if (irq !== exp)
    begin
      errors++;
      $display("[ERROR] t=%0t irq: got %b expected %b", $time, irq, exp);
    end
  endtask

  task automatic wait_irq_rise();
    int n;
    n = 0;
    while (irq !== 1'b1 && n < IRQ_WAIT)
    begin
      wait_clks(1);
      n++;
    end
    checks++;
    if (irq !== 1'b1)
    begin
      errors++;
      $display("irq never rose within %0d clocks of a button change (t=%0t)", IRQ_WAIT, $time);
    end
  endtask

  task automatic end_test(input string name);
    while (got_q.size() != 0)
      @(posedge clk);
    #2;
    test_no++;
    if (errors == test_err_base)
      $display("test %0d %s: passed", test_no, name);
    else
      $display("test %0d %s: failed, %0d errors", test_no, name, errors - test_err_base);
    test_err_base = errors;
  endtask

  // compares queued read bytes and watches miso_oe while deselected
  always @(posedge clk)
  begin
    if (got_q.size() > 0)
    begin
      cmp_got = got_q.pop_front();
      cmp_exp = exp_q.pop_front();
      cmp_adr = adr_q.pop_front();
      checks++;
      if (cmp_got !== cmp_exp)
      begin
        errors++;
        $display("[ERROR] t=%0t miso byte at adr %08h: got %02h expected %02h",
                 $time, cmp_adr, cmp_got, cmp_exp);
      end
    end
    if (csn)
      csn_high = csn_high + 1;
    else
      csn_high = 0;
    // csn reaches miso_oe through two synchronizer flops
    if (csn_high >= 3 && miso_oe !== 1'b0)
    begin
      errors++;
      $display("[ERROR] t=%0t miso_oe: got %b expected 0 while csn high", $time, miso_oe);
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin
    arst_n = 1'b0;
    csn = 1'b1;
    sclk = 1'b0;
    mosi = 1'b0;
    btn = '0;
    ref_btn = '0;
    ref_irq = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;
    wait_clks(4);

    // burst write and read back, covers increment and the dummy byte
    seed_word = next_rand();
    base_adr = {8'h00, seed_word[23:0]};
    spi_write(base_adr, 16);
    spi_read(base_adr, 16);
    end_test("ram burst");

    // addresses differing above the ram index hit the same bytes
    seed_word = next_rand();
    base_adr = {8'h3c, seed_word[23:0]};
    alias_adr = base_adr ^ 32'h0055_0400;
    spi_write(base_adr, 8);
    spi_read(alias_adr, 8);
    spi_write(alias_adr, 8);
    spi_read(base_adr, 8);
    end_test("ram alias");

    // debounced change raises irq and shows in the button register
    btn = new_btn(ref_btn);
    wait_irq_rise();
    ref_btn = btn;
    ref_irq = 1'b1;
    spi_read({`SPI_REGION_BTN, 24'h0}, 1);
    check_irq(1'b1);
    end_test("button irq");

    // status read returns the flag and clears it
    spi_read({`SPI_REGION_IRQ, 24'h0}, 1);
    ref_irq = 1'b0;
    check_irq(1'b0);
    spi_read({`SPI_REGION_IRQ, 24'h0}, 1);
    end_test("irq clear");

    // change while irq pending leaves the register alone
    btn = new_btn(ref_btn);
    wait_irq_rise();
    ref_btn = btn;
    ref_irq = 1'b1;
    btn = new_btn(ref_btn);
    wait_clks(IRQ_WAIT);
    check_irq(1'b1);
    spi_read({`SPI_REGION_BTN, 24'h0}, 1);
    // status frame without data bytes, only the prefetch clears the flag
    spi_read({`SPI_REGION_IRQ, 24'h0}, 0);
    ref_irq = 1'b0;
    wait_irq_rise();
    ref_btn = btn;
    ref_irq = 1'b1;
    spi_read({`SPI_REGION_BTN, 24'h0}, 1);
    end_test("irq pending");

    // button register ignores writes, miso_oe off while deselected
    spi_write({`SPI_REGION_BTN, 24'h0}, 2);
    spi_read({`SPI_REGION_BTN, 24'h0}, 1);
    checks++;
    if (miso_oe !== 1'b0)
    begin
      errors++;
      $display("[ERROR] t=%0t miso_oe: got %b expected 0", $time, miso_oe);
    end
    end_test("miso_oe and register write");

    // bound assertion failures count as errors
    errors = errors + UUT.u_props.fail_count;
    $display("tests: %0d, checks: %0d, errors: %0d", test_no, checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
src/spi_btn_pkg.sv
src/btn_irq_ctrl.sv
src/spi_frame_decode.sv
src/spi_bus_responder.sv
src/spi_miso_shift.sv
src/spi_ram_btn_top.sv
tb/spi_ram_btn_props.sv
tb/spi_ram_btn_tb.sv
